/* vlog.f */
+incdir+testbench
src/ctrlPkg.sv
src/stageIfs.sv
src/instrClassifier.sv
src/normalDecoder.sv
src/specialDecoder.sv
src/controlOutStage.sv
src/controlUnit.sv
testbench/controlUnitTb.sv

/* testbench/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control set, same field order as the DUT outputs
typedef struct packed {
	logic [aluOpWidth-1:0]  aluOp;
	logic                   writeEn1;
	logic                   writeEn2;
	logic [dataWidth-1:0]   immediate;
	logic [buffWidth-1:0]   buffCtrl;
	logic [regSelWidth-1:0] destSel;
	logic [regSelWidth-1:0] destSel2;
	logic [regSelWidth-1:0] srcSel;
	logic                   flagWrite;
	logic                   memWrite;
	logic                   memRead;
	logic [dataWidth-1:0]   addr;
} ctrlSet;

function automatic ctrlSet predictCtrl(input logic [17:0] word, input logic [2:0] flagBits);
	ctrlSet      c;
	logic [3:0]  opHi;
	logic [3:0]  dest;
	logic [3:0]  opLo;
	logic [4:0]  jumpCode;
	logic        toPort2;
	logic        aluWr;
	logic        movWr;
	logic        immMovWr;
	logic        memLoad;
	logic        taken;
	c        = '0;
	opHi     = word[15:12];
	dest     = word[11:8];
	opLo     = word[7:4];
	jumpCode = word[17:13];
	toPort2  = (dest == 4'd12) || (dest == 4'd13);
	aluWr    = 1'b0;
	movWr    = 1'b0;
	immMovWr = 1'b0;
	memLoad  = 1'b0;
	taken    = 1'b0;

	if (word[17:16] == 2'b00) begin
		c.destSel              = dest;
		c.destSel2             = dest;
		c.buffCtrl[buffPcInc]  = 1'b1;
		if (opHi <= 4'd1) begin
			c.aluOp              = opLo;
			c.srcSel             = word[3:0];
			c.buffCtrl[buffSrc]  = 1'b1;
		end else begin
			c.aluOp              = opHi;
			c.srcSel             = dest;
			c.immediate          = {8'h00, word[7:0]};
			c.buffCtrl[buffImm]  = 1'b1;
		end
		if (opHi == 4'd0) begin
			case (opLo)
				2, 3, 4, 5, 6, 7, 8, 9, 10, 12: begin
					c.flagWrite = 1'b1;
					aluWr       = 1'b1;
				end
				13, 14: c.flagWrite = 1'b1;
				15: movWr = 1'b1;
				11: begin
					if (dest == 4'd12) begin
						c.flagWrite            = 1'b1;
						c.writeEn1             = 1'b1;
						c.writeEn2             = 1'b1;
						c.buffCtrl[buffAlu1]   = 1'b1;
						c.buffCtrl[buffMulHi]  = 1'b1;
					end
				end
				default: ;
			endcase
		end else if (opHi == 4'd1) begin
			if (opLo == 4'd0) begin
				c.memRead              = 1'b1;
				c.buffCtrl[buffMemAddr] = 1'b1;
				memLoad                = 1'b1;
			end else if (opLo == 4'd1) begin
				c.memWrite              = 1'b1;
				c.buffCtrl[buffMemAddr] = 1'b1;
				c.buffCtrl[buffMemData] = 1'b1;
			end
		end else begin
			case (opHi)
				2, 3, 4, 5, 6, 7, 8, 9, 10: begin
					c.flagWrite = 1'b1;
					aluWr       = 1'b1;
				end
				13, 14: c.flagWrite = 1'b1;
				15: immMovWr = 1'b1;
				default: ;
			endcase
		end
		// Port choice for ordinary and special destinations
		if (aluWr || movWr || immMovWr || memLoad) begin
			c.writeEn1 = !toPort2;
			c.writeEn2 = toPort2;
		end
		c.buffCtrl[buffAlu1]    = c.buffCtrl[buffAlu1] | (aluWr && !toPort2);
		c.buffCtrl[buffAlu2]    = aluWr && toPort2;
		c.buffCtrl[buffMov1]    = movWr && !toPort2;
		c.buffCtrl[buffMov2]    = movWr && toPort2;
		c.buffCtrl[buffImmMov1] = immMovWr && !toPort2;
		c.buffCtrl[buffImmMov2] = immMovWr && toPort2;
		c.buffCtrl[buffMem1]    = memLoad && !toPort2;
		c.buffCtrl[buffMem2]    = memLoad && toPort2;
	end else if (word[17:16] != 2'b11) begin
		c.destSel               = 4'd15;
		c.addr                  = {2'b00, word[13:0]};
		c.buffCtrl[buffSrc]     = 1'b1;
		c.buffCtrl[buffAddrImm] = 1'b1;
		case (word[17:14])
			4'b0100: begin
				c.memWrite              = 1'b1;
				c.buffCtrl[buffMem1]    = 1'b1;
				c.buffCtrl[buffPcInc]   = 1'b1;
				c.buffCtrl[buffMemAddr] = 1'b1;
			end
			4'b0101: begin
				c.memRead             = 1'b1;
				c.writeEn1            = 1'b1;
				c.buffCtrl[buffMem1]  = 1'b1;
				c.buffCtrl[buffPcInc] = 1'b1;
			end
			4'b0110: begin
				c.memWrite              = 1'b1;
				c.buffCtrl[buffMemData] = 1'b1;
				c.buffCtrl[buffPcInc]   = 1'b1;
			end
			4'b0111: begin
				c.memRead           = 1'b1;
				c.buffCtrl[buffRet] = 1'b1;
			end
			default: begin
				// Flags are low, negative, zero from bit 2 down
				case (jumpCode)
					5'b10000: taken = flagBits[1];
					5'b10001: taken = flagBits[1] || flagBits[0];
					5'b10010: taken = !flagBits[0];
					5'b10011: taken = flagBits[0];
					5'b10100: taken = 1'b1;
					5'b10101: taken = flagBits[2] || flagBits[0];
					5'b10110: taken = flagBits[2];
					default:  taken = 1'b0;
				endcase
				c.buffCtrl[buffJump]  = taken;
				c.buffCtrl[buffPcInc] = !taken;
			end
		endcase
	end
	return c;
endfunction

`endif

/* testbench/controlUnitTb.sv */
`default_nettype none

module controlUnitTb;
	import ctrlPkg::*;

	`include "decodeModel.svh"

	localparam int regWords     = 64;
	localparam int memImmWords  = 54;
	localparam int addrWords    = 68;
	localparam int illegalWords = 8;
	localparam int streamWords  = 200;
	localparam int totalWords   = regWords + memImmWords + addrWords + illegalWords + streamWords;
	localparam int limitCycles  = totalWords * 20 + 200;

	logic                   clk;
	logic                   arstN;
	logic                   instrValid;
	logic                   instrReady;
	logic [instrWidth-1:0]  instruction;
	logic [flagWidth-1:0]   flags;
	logic                   ctrlValid;
	logic                   ctrlReady;
	logic [aluOpWidth-1:0]  aluOp;
	logic                   writeEn1;
	logic                   writeEn2;
	logic [dataWidth-1:0]   immediate;
	logic [buffWidth-1:0]   buffCtrl;
	logic [regSelWidth-1:0] destSel;
	logic [regSelWidth-1:0] destSel2;
	logic [regSelWidth-1:0] srcSel;
	logic                   flagWrite;
	logic                   memWrite;
	logic                   memRead;
	logic [dataWidth-1:0]   addr;

	ctrlSet      observed;
	ctrlSet      held;
	ctrlSet      expQ[$];
	logic        stalled;
	logic        randomReady;
	int          issued;
	int          received;

	controlUnit i_dut (
		.clk         (clk),
		.arstN       (arstN),
		.instrValid  (instrValid),
		.instrReady  (instrReady),
		.instruction (instruction),
		.flags       (flags),
		.ctrlValid   (ctrlValid),
		.ctrlReady   (ctrlReady),
		.aluOp       (aluOp),
		.writeEn1    (writeEn1),
		.writeEn2    (writeEn2),
		.immediate   (immediate),
		.buffCtrl    (buffCtrl),
		.destSel     (destSel),
		.destSel2    (destSel2),
		.srcSel      (srcSel),
		.flagWrite   (flagWrite),
		.memWrite    (memWrite),
		.memRead     (memRead),
		.addr        (addr)
	);

	assign observed = {aluOp, writeEn1, writeEn2, immediate, buffCtrl, destSel, destSel2,
		srcSel, flagWrite, memWrite, memRead, addr};

	always #5 clk = ~clk;

	//////////////////////////////
	// Checking
	//////////////////////////////
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compareValue(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("error at time %0t: %s is 'h%0h, expected 'h%0h", $time, what,
				actual, expected));
		end
	endtask

	task automatic compareCtrl(input string tag, input ctrlSet got, input ctrlSet exp);
		compareValue({tag, " aluOp"}, got.aluOp, exp.aluOp);
		compareValue({tag, " writeEn1"}, got.writeEn1, exp.writeEn1);
		compareValue({tag, " writeEn2"}, got.writeEn2, exp.writeEn2);
		compareValue({tag, " immediate"}, got.immediate, exp.immediate);
		compareValue({tag, " buffCtrl"}, got.buffCtrl, exp.buffCtrl);
		compareValue({tag, " destSel"}, got.destSel, exp.destSel);
		compareValue({tag, " destSel2"}, got.destSel2, exp.destSel2);
		compareValue({tag, " srcSel"}, got.srcSel, exp.srcSel);
		compareValue({tag, " flagWrite"}, got.flagWrite, exp.flagWrite);
		compareValue({tag, " memWrite"}, got.memWrite, exp.memWrite);
		compareValue({tag, " memRead"}, got.memRead, exp.memRead);
		compareValue({tag, " addr"}, got.addr, exp.addr);
	endtask

	// Output side sampled mid-cycle, a transfer happens at the next rising edge
	always @(negedge clk) begin
		if (arstN) begin
			if (stalled) begin
				compareValue("held ctrlValid", ctrlValid, 1);
				compareCtrl("held", observed, held);
			end
			if (ctrlValid && ctrlReady) begin
				if (expQ.size() == 0) begin
					failRun("an output transfer arrived with no instruction pending");
				end else begin
					compareCtrl("output", observed, expQ.pop_front());
					received++;
				end
				stalled = 1'b0;
			end else begin
				stalled = ctrlValid;
				held    = observed;
			end
		end
	end

	// Back-pressure source
	always @(posedge clk) begin
		#1;
		if (randomReady) begin
			ctrlReady = ($urandom % 2) == 0;
		end else begin
			ctrlReady = 1'b1;
		end
	end

	initial begin
		repeat (limitCycles) @(posedge clk);
		failRun($sformatf("run timed out after %0d cycles", limitCycles));
	end

	//////////////////////////////
	// Driving
	//////////////////////////////
	// Leaves instrValid high so the next word can follow back to back
	task automatic sendInstr(input logic [17:0] word, input logic [2:0] flagBits);
		instruction = word;
		flags       = flagBits;
		instrValid  = 1'b1;
		@(negedge clk);
		// Full rate while the output side never stalls
		if (!randomReady) begin
			compareValue("instrReady without back-pressure", instrReady, 1);
		end
		while (!instrReady) begin
			@(negedge clk);
		end
		expQ.push_back(predictCtrl(word, flagBits));
		issued++;
		@(posedge clk);
		#1;
	endtask

	task automatic drainAndCount();
		instrValid  = 1'b0;
		randomReady <= 1'b0;
		while (expQ.size() != 0) begin
			@(posedge clk);
			#1;
		end
		compareValue("transfer count", received, issued);
	endtask

	task automatic checkResetState();
		@(negedge clk);
		compareValue("reset ctrlValid", ctrlValid, 0);
		compareValue("reset instrReady", instrReady, 1);
		compareCtrl("reset", observed, '0);
		@(posedge clk);
		#1;
	endtask

	task automatic decodeRegisterGroup();
		logic [3:0] dests [4];
		dests = '{4'd3, 4'd12, 4'd13, 4'd15};
		for (int op = 0; op < 16; op++) begin
			foreach (dests[d]) begin
				sendInstr({2'b00, 4'd0, dests[d], 4'(op), 4'(op + d)}, 3'($urandom));
			end
		end
		drainAndCount();
	endtask

	task automatic decodeMemImmGroups();
		logic [3:0] dests [3];
		dests = '{4'd5, 4'd12, 4'd13};
		for (int op = 0; op < 4; op++) begin
			foreach (dests[d]) begin
				sendInstr({2'b00, 4'd1, dests[d], 4'(op), 4'($urandom)}, 3'($urandom));
			end
		end
		// Immediate high bit set often, to catch sign extension
		for (int op = 2; op < 16; op++) begin
			foreach (dests[d]) begin
				sendInstr({2'b00, 4'(op), dests[d], 8'($urandom)}, 3'($urandom));
			end
		end
		drainAndCount();
	endtask

	task automatic decodeAddressGroup();
		logic [3:0] ops [4];
		logic [4:0] jumps [8];
		ops   = '{opCall, opMovMri, opMovRmi, opRet};
		jumps = '{opJl, opJle, opJne, opJe, opJ, opJbe, opJb, 5'b10111};
		foreach (ops[i]) begin
			sendInstr({ops[i], 14'($urandom)}, 3'($urandom));
		end
		foreach (jumps[j]) begin
			for (int f = 0; f < 8; f++) begin
				sendInstr({jumps[j], 13'($urandom)}, 3'(f));
			end
		end
		drainAndCount();
	endtask

	task automatic decodeIllegal();
		for (int i = 0; i < illegalWords; i++) begin
			sendInstr({2'b11, 16'($urandom)}, 3'(i));
		end
		drainAndCount();
	endtask

	task automatic streamUnderBackpressure();
		randomReady <= 1'b1;
		for (int i = 0; i < streamWords; i++) begin
			sendInstr(18'($urandom), 3'($urandom));
		end
		drainAndCount();
	endtask

	initial begin
		void'($urandom(32'hbf57_40ab));
		clk         = 1'b0;
		arstN       = 1'b0;
		instrValid  = 1'b0;
		instruction = '0;
		flags       = '0;
		ctrlReady   = 1'b1;
		randomReady = 1'b0;
		stalled     = 1'b0;
		issued      = 0;
		received    = 0;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;

		checkResetState();
		decodeRegisterGroup();
		decodeMemImmGroups();
		decodeAddressGroup();
		decodeIllegal();
		streamUnderBackpressure();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`default_nettype none

module controlUnit (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            instrValid,
	output logic                            instrReady,
	input  logic [ctrlPkg::instrWidth-1:0]  instruction,
	input  logic [ctrlPkg::flagWidth-1:0]   flags,
	output logic                            ctrlValid,
	input  logic                            ctrlReady,
	output logic [ctrlPkg::aluOpWidth-1:0]  aluOp,
	output logic                            writeEn1,
	output logic                            writeEn2,
	output logic [ctrlPkg::dataWidth-1:0]   immediate,
	output logic [ctrlPkg::buffWidth-1:0]   buffCtrl,
	output logic [ctrlPkg::regSelWidth-1:0] destSel,
	output logic [ctrlPkg::regSelWidth-1:0] destSel2,
	output logic [ctrlPkg::regSelWidth-1:0] srcSel,
	output logic                            flagWrite,
	output logic                            memWrite,
	output logic                            memRead,
	output logic [ctrlPkg::dataWidth-1:0]   addr
);

	//////////////////////////////
	// Stage buses
	//////////////////////////////
	classIf clsBus ();
	ctrlIf  normalBus ();
	ctrlIf  specialBus ();

	// Stage 1, register and classify
	instrClassifier classifier (
		.clk         (clk),
		.arstN       (arstN),
		.instrValid  (instrValid),
		.instrReady  (instrReady),
		.instruction (instruction),
		.flags       (flags),
		.out         (clsBus.producer)
	);

	normalDecoder normalDec (
		.in   (clsBus.monitor),
		.ctrl (normalBus.source)
	);

	specialDecoder specialDec (
		.in   (clsBus.monitor),
		.ctrl (specialBus.source)
	);

	// Stage 2, pick by class and hold for the datapath
	controlOutStage outStage (
		.clk       (clk),
		.arstN     (arstN),
		.in        (clsBus.consumer),
		.normal    (normalBus.sink),
		.special   (specialBus.sink),
		.ctrlValid (ctrlValid),
		.ctrlReady (ctrlReady),
		.aluOp     (aluOp),
		.writeEn1  (writeEn1),
		.writeEn2  (writeEn2),
		.immediate (immediate),
		.buffCtrl  (buffCtrl),
		.destSel   (destSel),
		.destSel2  (destSel2),
		.srcSel    (srcSel),
		.flagWrite (flagWrite),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.addr      (addr)
	);

endmodule

`default_nettype wire

/* src/controlOutStage.sv */
`default_nettype none

module controlOutStage (
	input  logic                            clk,
	input  logic                            arstN,
	classIf.consumer                        in,
	ctrlIf.sink                             normal,
	ctrlIf.sink                             special,
	output logic                            ctrlValid,
	input  logic                            ctrlReady,
	output logic [ctrlPkg::aluOpWidth-1:0]  aluOp,
	output logic                            writeEn1,
	output logic                            writeEn2,
	output logic [ctrlPkg::dataWidth-1:0]   immediate,
	output logic [ctrlPkg::buffWidth-1:0]   buffCtrl,
	output logic [ctrlPkg::regSelWidth-1:0] destSel,
	output logic [ctrlPkg::regSelWidth-1:0] destSel2,
	output logic [ctrlPkg::regSelWidth-1:0] srcSel,
	output logic                            flagWrite,
	output logic                            memWrite,
	output logic                            memRead,
	output logic [ctrlPkg::dataWidth-1:0]   addr
);
	import ctrlPkg::*;

	logic take;
	logic selNormal;
	logic selSpecial;

	assign in.ready = !ctrlValid || ctrlReady;
	assign take     = in.valid && in.ready;

	// Illegal words select neither and register zeros
	assign selNormal  = (in.cls == clsReg) || (in.cls == clsMem) || (in.cls == clsImm);
	assign selSpecial = (in.cls == clsAddr);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlValid <= 1'b0;
			aluOp     <= '0;
			writeEn1  <= 1'b0;
			writeEn2  <= 1'b0;
			immediate <= '0;
			buffCtrl  <= '0;
			destSel   <= '0;
			destSel2  <= '0;
			srcSel    <= '0;
			flagWrite <= 1'b0;
			memWrite  <= 1'b0;
			memRead   <= 1'b0;
			addr      <= '0;
		end else begin
			if (in.ready) begin
				ctrlValid <= in.valid;
			end
			if (take) begin
				aluOp     <= selNormal ? normal.aluOp : selSpecial ? special.aluOp : '0;
				writeEn1  <= selNormal ? normal.writeEn1 : selSpecial && special.writeEn1;
				writeEn2  <= selNormal ? normal.writeEn2 : selSpecial && special.writeEn2;
				immediate <= selNormal ? normal.immediate : selSpecial ? special.immediate : '0;
				buffCtrl  <= selNormal ? normal.buffCtrl : selSpecial ? special.buffCtrl : '0;
				destSel   <= selNormal ? normal.destSel : selSpecial ? special.destSel : '0;
				destSel2  <= selNormal ? normal.destSel2 : selSpecial ? special.destSel2 : '0;
				srcSel    <= selNormal ? normal.srcSel : selSpecial ? special.srcSel : '0;
				flagWrite <= selNormal ? normal.flagWrite : selSpecial && special.flagWrite;
				memWrite  <= selNormal ? normal.memWrite : selSpecial && special.memWrite;
				memRead   <= selNormal ? normal.memRead : selSpecial && special.memRead;
				addr      <= selNormal ? normal.addr : selSpecial ? special.addr : '0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/specialDecoder.sv */
`default_nettype none

module specialDecoder (
	classIf.monitor in,
	ctrlIf.source   ctrl
);
	import ctrlPkg::*;

	logic       low;
	logic       negative;
	logic       zero;
	logic [4:0] jumpCode;
	logic       jumpTaken;

	assign low      = in.flags[flagLow];
	assign negative = in.flags[flagNeg];
	assign zero     = in.flags[flagZero];

	assign jumpCode = {in.word.special.op4, in.word.special.addr14[13]};

	//////////////////////////////
	// Jump conditions
	//////////////////////////////
	always_comb begin
		case (jumpCode)
			opJl:    jumpTaken = negative;
			opJle:   jumpTaken = negative || zero;
			opJne:   jumpTaken = !zero;
			opJe:    jumpTaken = zero;
			opJ:     jumpTaken = 1'b1;
			opJbe:   jumpTaken = low || zero;
			opJb:    jumpTaken = low;
			default: jumpTaken = 1'b0;
		endcase
	end

	always_comb begin
		ctrl.aluOp     = '0;
		ctrl.writeEn1  = 1'b0;
		ctrl.writeEn2  = 1'b0;
		ctrl.immediate = '0;
		ctrl.buffCtrl  = '0;
		ctrl.destSel   = linkReg;
		ctrl.destSel2  = '0;
		ctrl.srcSel    = '0;
		ctrl.flagWrite = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.memRead   = 1'b0;
		ctrl.addr      = {{(dataWidth - 14){1'b0}}, in.word.special.addr14};

		ctrl.buffCtrl[buffSrc]     = 1'b1;
		ctrl.buffCtrl[buffAddrImm] = 1'b1;

		case (in.word.special.op4)
			opCall: begin
				// Return address pushed to memory
				ctrl.memWrite              = 1'b1;
				ctrl.buffCtrl[buffMem1]    = 1'b1;
				ctrl.buffCtrl[buffPcInc]   = 1'b1;
				ctrl.buffCtrl[buffMemAddr] = 1'b1;
			end
			opMovMri: begin
				ctrl.memRead             = 1'b1;
				ctrl.writeEn1            = 1'b1;
				ctrl.buffCtrl[buffMem1]  = 1'b1;
				ctrl.buffCtrl[buffPcInc] = 1'b1;
			end
			opMovRmi: begin
				ctrl.memWrite              = 1'b1;
				ctrl.buffCtrl[buffMemData] = 1'b1;
				ctrl.buffCtrl[buffPcInc]   = 1'b1;
			end
			opRet: begin
				ctrl.memRead           = 1'b1;
				ctrl.buffCtrl[buffRet] = 1'b1;
			end
			default: begin
				// Jumps, unknown codes just step the PC
				ctrl.buffCtrl[buffJump]  = jumpTaken;
				ctrl.buffCtrl[buffPcInc] = !jumpTaken;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/normalDecoder.sv */
`default_nettype none

module normalDecoder (
	classIf.monitor in,
	ctrlIf.source   ctrl
);
	import ctrlPkg::*;

	logic specialDest;

	// r12 and r13 go through the second write port
	assign specialDest = (in.word.normal.dest == specialRegA) ||
		(in.word.normal.dest == specialRegB);

	always_comb begin
		ctrl.aluOp     = '0;
		ctrl.writeEn1  = 1'b0;
		ctrl.writeEn2  = 1'b0;
		ctrl.immediate = '0;
		ctrl.buffCtrl  = '0;
		ctrl.destSel   = '0;
		ctrl.destSel2  = '0;
		ctrl.srcSel    = '0;
		ctrl.flagWrite = 1'b0;
		ctrl.memWrite  = 1'b0;
		ctrl.memRead   = 1'b0;
		ctrl.addr      = '0;

		case (in.word.normal.opHi)
			//////////////////////////////
			// Register form
			//////////////////////////////
			4'd0: begin
				ctrl.aluOp              = in.word.normal.opLo;
				ctrl.srcSel             = in.word.normal.src;
				ctrl.destSel            = in.word.normal.dest;
				ctrl.destSel2           = in.word.normal.dest;
				ctrl.buffCtrl[buffSrc]   = 1'b1;
				ctrl.buffCtrl[buffPcInc] = 1'b1;
				case (in.word.normal.opLo)
					opAdd, opSub, opAnd, opOr, opXor, opNot, opLsh, opRsh, opArsh,
					opFmul: begin
						ctrl.flagWrite          = 1'b1;
						ctrl.writeEn1           = !specialDest;
						ctrl.writeEn2           = specialDest;
						ctrl.buffCtrl[buffAlu1] = !specialDest;
						ctrl.buffCtrl[buffAlu2] = specialDest;
					end
					opCmp, opCmpr: begin
						ctrl.flagWrite = 1'b1;
					end
					opMovr: begin
						ctrl.writeEn1           = !specialDest;
						ctrl.writeEn2           = specialDest;
						ctrl.buffCtrl[buffMov1] = !specialDest;
						ctrl.buffCtrl[buffMov2] = specialDest;
					end
					opMul: begin
						// Low half to r12 via port 1, high half via port 2
						if (in.word.normal.dest == specialRegA) begin
							ctrl.flagWrite           = 1'b1;
							ctrl.writeEn1            = 1'b1;
							ctrl.writeEn2            = 1'b1;
							ctrl.buffCtrl[buffAlu1]  = 1'b1;
							ctrl.buffCtrl[buffMulHi] = 1'b1;
						end
					end
					default: ;
				endcase
			end
			//////////////////////////////
			// Memory moves
			//////////////////////////////
			4'd1: begin
				ctrl.aluOp              = in.word.normal.opLo;
				ctrl.srcSel             = in.word.normal.src;
				ctrl.destSel            = in.word.normal.dest;
				ctrl.destSel2           = in.word.normal.dest;
				ctrl.buffCtrl[buffSrc]   = 1'b1;
				ctrl.buffCtrl[buffPcInc] = 1'b1;
				if (in.word.normal.opLo == opMovMr) begin
					ctrl.memRead               = 1'b1;
					ctrl.buffCtrl[buffMemAddr] = 1'b1;
					ctrl.writeEn1              = !specialDest;
					ctrl.writeEn2              = specialDest;
					ctrl.buffCtrl[buffMem1]    = !specialDest;
					ctrl.buffCtrl[buffMem2]    = specialDest;
				end else if (in.word.normal.opLo == opMovRm) begin
					ctrl.memWrite              = 1'b1;
					ctrl.buffCtrl[buffMemAddr] = 1'b1;
					ctrl.buffCtrl[buffMemData] = 1'b1;
				end
			end
			//////////////////////////////
			// Immediate form
			//////////////////////////////
			default: begin
				ctrl.aluOp              = in.word.normal.opHi;
				ctrl.srcSel             = in.word.normal.dest;
				ctrl.destSel            = in.word.normal.dest;
				ctrl.destSel2           = in.word.normal.dest;
				ctrl.immediate          = {{(dataWidth - 8){1'b0}}, in.word.normal.opLo,
					in.word.normal.src};
				ctrl.buffCtrl[buffImm]   = 1'b1;
				ctrl.buffCtrl[buffPcInc] = 1'b1;
				case (in.word.normal.opHi)
					opAdd, opSub, opAnd, opOr, opXor, opNot, opLsh, opRsh, opArsh: begin
						ctrl.flagWrite          = 1'b1;
						ctrl.writeEn1           = !specialDest;
						ctrl.writeEn2           = specialDest;
						ctrl.buffCtrl[buffAlu1] = !specialDest;
						ctrl.buffCtrl[buffAlu2] = specialDest;
					end
					opCmp, opCmpr: begin
						ctrl.flagWrite = 1'b1;
					end
					opMovr: begin
						ctrl.writeEn1              = !specialDest;
						ctrl.writeEn2              = specialDest;
						ctrl.buffCtrl[buffImmMov1] = !specialDest;
						ctrl.buffCtrl[buffImmMov2] = specialDest;
					end
					// MUL and FMUL have no immediate form
					default: ;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/instrClassifier.sv */
`default_nettype none

module instrClassifier (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           instrValid,
	output logic                           instrReady,
	input  logic [ctrlPkg::instrWidth-1:0] instruction,
	input  logic [ctrlPkg::flagWidth-1:0]  flags,
	classIf.producer                       out
);
	import ctrlPkg::*;

	instrWord  inWord;
	instrClass nextCls;
	logic      take;

	assign inWord = instruction;

	// Empty, or the word held here leaves this cycle
	assign instrReady = !out.valid || out.ready;
	assign take       = instrValid && instrReady;

	//////////////////////////////
	// Top level decode
	//////////////////////////////
	always_comb begin
		case (inWord.normal.top)
			2'b00: begin
				if (inWord.normal.opHi == 4'd0) begin
					nextCls = clsReg;
				end else if (inWord.normal.opHi == 4'd1) begin
					nextCls = clsMem;
				end else begin
					nextCls = clsImm;
				end
			end
			2'b01, 2'b10: begin
				nextCls = clsAddr;
			end
			default: begin
				// Old stack group, no longer decoded
				nextCls = clsIllegal;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			out.valid <= 1'b0;
		end else if (instrReady) begin
			out.valid <= instrValid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.word  <= inWord;
			out.flags <= flags;
			out.cls   <= nextCls;
		end
	end

endmodule

`default_nettype wire

/* src/stageIfs.sv */
`default_nettype none

// Classified instruction between the input stage and the output stage
interface classIf;
	import ctrlPkg::*;

	logic                 valid;
	logic                 ready;
	instrClass            cls;
	instrWord             word;
	logic [flagWidth-1:0] flags;

	modport producer (output valid, cls, word, flags, input ready);
	modport consumer (input valid, cls, word, flags, output ready);
	// Decoders only look
	modport monitor (input valid, ready, cls, word, flags);
endinterface

// One full control set, combinational from the classified word
interface ctrlIf;
	import ctrlPkg::*;

	logic [aluOpWidth-1:0]  aluOp;
	logic                   writeEn1;
	logic                   writeEn2;
	logic [dataWidth-1:0]   immediate;
	logic [buffWidth-1:0]   buffCtrl;
	logic [regSelWidth-1:0] destSel;
	logic [regSelWidth-1:0] destSel2;
	logic [regSelWidth-1:0] srcSel;
	logic                   flagWrite;
	logic                   memWrite;
	logic                   memRead;
	logic [dataWidth-1:0]   addr;

	modport source (output aluOp, writeEn1, writeEn2, immediate, buffCtrl, destSel,
		destSel2, srcSel, flagWrite, memWrite, memRead, addr);
	modport sink (input aluOp, writeEn1, writeEn2, immediate, buffCtrl, destSel,
		destSel2, srcSel, flagWrite, memWrite, memRead, addr);
endinterface

`default_nettype wire

/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int instrWidth  = 18;
	localparam int dataWidth   = 16;
	localparam int regSelWidth = 4;
	localparam int aluOpWidth  = 4;
	localparam int buffWidth   = 22;
	localparam int flagWidth   = 3;

	// Registers behind the second write port
	localparam logic [3:0] specialRegA = 4'd12;
	localparam logic [3:0] specialRegB = 4'd13;
	localparam logic [3:0] linkReg     = 4'd15;

	// Flag bit positions
	localparam int flagLow  = 2;
	localparam int flagNeg  = 1;
	localparam int flagZero = 0;

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam logic [3:0] opMovMr = 4'd0;
	localparam logic [3:0] opMovRm = 4'd1;
	localparam logic [3:0] opAdd   = 4'd2;
	localparam logic [3:0] opSub   = 4'd3;
	localparam logic [3:0] opAnd   = 4'd4;
	localparam logic [3:0] opOr    = 4'd5;
	localparam logic [3:0] opXor   = 4'd6;
	localparam logic [3:0] opNot   = 4'd7;
	localparam logic [3:0] opLsh   = 4'd8;
	localparam logic [3:0] opRsh   = 4'd9;
	localparam logic [3:0] opArsh  = 4'd10;
	localparam logic [3:0] opMul   = 4'd11;
	localparam logic [3:0] opFmul  = 4'd12;
	localparam logic [3:0] opCmp   = 4'd13;
	localparam logic [3:0] opCmpr  = 4'd14;
	localparam logic [3:0] opMovr  = 4'd15;

	// 14-bit address group
	localparam logic [3:0] opCall   = 4'b0100;
	localparam logic [3:0] opMovMri = 4'b0101;
	localparam logic [3:0] opMovRmi = 4'b0110;
	localparam logic [3:0] opRet    = 4'b0111;

	// Jumps, op4 plus one more bit
	localparam logic [4:0] opJl  = 5'b10000;
	localparam logic [4:0] opJle = 5'b10001;
	localparam logic [4:0] opJne = 5'b10010;
	localparam logic [4:0] opJe  = 5'b10011;
	localparam logic [4:0] opJ   = 5'b10100;
	localparam logic [4:0] opJbe = 5'b10101;
	localparam logic [4:0] opJb  = 5'b10110;

	//////////////////////////////
	// Buffer enables
	//////////////////////////////
	localparam int buffImm     = 0;
	localparam int buffSrc     = 1;
	localparam int buffAlu1    = 2;
	localparam int buffAlu2    = 3;
	localparam int buffImmMov1 = 4;
	localparam int buffImmMov2 = 5;
	localparam int buffMov1    = 6;
	localparam int buffMov2    = 7;
	localparam int buffMemAddr = 8;
	localparam int buffAddrImm = 9;
	localparam int buffMemData = 10;
	localparam int buffMem1    = 12;
	localparam int buffMem2    = 13;
	localparam int buffRet     = 14;
	localparam int buffJump    = 15;
	localparam int buffPcInc   = 16;
	// High half of the MUL product into r12
	localparam int buffMulHi   = 21;

	typedef enum logic [2:0] {
		clsReg,
		clsMem,
		clsImm,
		clsAddr,
		clsIllegal
	} instrClass;

	typedef union packed {
		struct packed {
			logic [1:0]             top;
			logic [aluOpWidth-1:0]  opHi;
			logic [regSelWidth-1:0] dest;
			logic [aluOpWidth-1:0]  opLo;
			logic [regSelWidth-1:0] src;
		} normal;
		struct packed {
			logic [3:0]  op4;
			logic [13:0] addr14;
		} special;
	} instrWord;

endpackage

`default_nettype wire
